/* merge_2x1_seq.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module merge_2x1_seq #(
    parameter int  TAG_IN_WIDTH   = 0,
    localparam int TAG_PORT_WIDTH = (TAG_IN_WIDTH > 0) ? TAG_IN_WIDTH : 1
) (
    input  logic                         clk,
    input  logic                         i_reset,
    input  merge_pkg::merge_mode_e       i_mode,
    input  logic [1:0]                   i_valid,
    input  logic [`MERGE_DATA_WIDTH-1:0] i_data_low,
    input  logic [`MERGE_DATA_WIDTH-1:0] i_data_high,
    input  logic [TAG_PORT_WIDTH-1:0]    i_tag_low,
    input  logic [TAG_PORT_WIDTH-1:0]    i_tag_high,
    input  logic                         i_accept,
    output logic [1:0]                   o_accept,
    output logic                         o_valid,
    output logic [`MERGE_DATA_WIDTH-1:0] o_data,
    output logic [TAG_IN_WIDTH:0]        o_tag
);

    import merge_pkg::*;

    logic                         r_valid;
    logic [`MERGE_DATA_WIDTH-1:0] r_data;
    logic [TAG_IN_WIDTH:0]        r_tag;
    // 1 = high branch served last
    logic                         r_last_high;
    logic                         w_pick_high;
    logic                         w_room;
    logic                         w_load;
    logic [`MERGE_DATA_WIDTH-1:0] w_sel_data;
    logic [TAG_PORT_WIDTH-1:0]    w_sel_tag;
    logic [TAG_IN_WIDTH:0]        w_next_tag;

    //////////////////////////////////////////////////////////////////////
    // arbiter
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_mode)
            // the branch not served last wins a tie
            MODE_LAST_SERVED: w_pick_high = (&i_valid) ? ~r_last_high : i_valid[1];
            MODE_FIX_LOW:     w_pick_high = ~i_valid[0];
            MODE_FIX_HIGH:    w_pick_high = i_valid[1];
            default:          w_pick_high = 1'b0;
        endcase
    end

    // register empty or draining this cycle
    assign w_room = (i_mode != MODE_HOLD) && (!r_valid || i_accept);
    assign w_load = w_room && (|i_valid);

    // grant only to the winning branch
    assign o_accept = {w_load & w_pick_high, w_load & ~w_pick_high};

    assign w_sel_data = w_pick_high ? i_data_high : i_data_low;
    assign w_sel_tag  = w_pick_high ? i_tag_high : i_tag_low;

    // branch bit on top so the root tag reads as the lane number
    generate
        if (TAG_IN_WIDTH == 0)
        begin : g_leaf_tag
            assign w_next_tag = w_pick_high;
        end
        else
        begin : g_inner_tag
            assign w_next_tag = {w_pick_high, w_sel_tag};
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (w_load)
        begin
            r_data <= w_sel_data;
            r_tag  <= w_next_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            r_valid     <= 1'b0;
            // low branch wins first
            r_last_high <= 1'b1;
        end
        else
        begin
            if (w_load)
            begin
                r_valid <= 1'b1;
            end
            else if (i_accept)
            begin
                r_valid <= 1'b0;
            end
            // pointer only tracks grants in fair mode
            if (w_load && (i_mode == MODE_LAST_SERVED))
            begin
                r_last_high <= w_pick_high;
            end
        end
    end

    assign o_valid = r_valid;
    assign o_data  = r_data;
    assign o_tag   = r_tag;

endmodule

`default_nettype wire

/* merge_cmd_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module merge_cmd_decode (
    input  logic                    clk,
    input  logic                    i_reset,
    input  logic                    i_cmd_valid,
    input  merge_pkg::merge_cmd_e   i_cmd,
    output merge_pkg::merge_mode_e  o_mode
);

    import merge_pkg::*;

    merge_mode_e r_mode;

    //////////////////////////////////////////////////////////////////////
    // each opcode maps to a mode held until the next command
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            // tree comes up enabled in fair arbitration
            r_mode <= MODE_LAST_SERVED;
        end
        else if (i_cmd_valid)
        begin
            case (i_cmd)
                CMD_ROUND_ROBIN: r_mode <= MODE_LAST_SERVED;
                CMD_PRIO_LOW:    r_mode <= MODE_FIX_LOW;
                CMD_PRIO_HIGH:   r_mode <= MODE_FIX_HIGH;
                // hold doubles as the tree disable
                CMD_HOLD:        r_mode <= MODE_HOLD;
                default:         r_mode <= r_mode;
            endcase
        end
    end

    // same mode fans out to all three switches
    assign o_mode = r_mode;

endmodule

`default_nettype wire

/* merge_credit_out.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module merge_credit_out (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_valid,
    input  logic [`MERGE_DATA_WIDTH-1:0] i_data,
    input  logic [`MERGE_TAG_WIDTH-1:0]  i_tag,
    input  logic                         i_out_credit,
    output logic                         o_accept,
    output logic                         o_valid,
    output logic [`MERGE_DATA_WIDTH-1:0] o_data,
    output logic [`MERGE_TAG_WIDTH-1:0]  o_tag
);

    logic                           r_full;
    logic [`MERGE_DATA_WIDTH-1:0]   r_data;
    logic [`MERGE_TAG_WIDTH-1:0]    r_tag;
    logic [`MERGE_CREDIT_WIDTH-1:0] r_credit_cnt;
    logic                           w_load;

    // issue on the first cycle a credit is there
    assign o_valid  = r_full && (r_credit_cnt != '0);
    // refill behind the word leaving now
    assign o_accept = !r_full || o_valid;
    assign w_load   = i_valid && o_accept;

    always_ff @(posedge clk)
    begin
        if (w_load)
        begin
            r_data <= i_data;
            r_tag  <= i_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // holding flag and downstream credit pool
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            r_full       <= 1'b0;
            r_credit_cnt <= `MERGE_CREDIT_WIDTH'(`MERGE_OUT_CREDITS);
        end
        else
        begin
            if (w_load)
            begin
                r_full <= 1'b1;
            end
            else if (o_valid)
            begin
                r_full <= 1'b0;
            end
            // spend and return in one cycle cancel out
            case ({o_valid, i_out_credit})
                2'b10:   r_credit_cnt <= r_credit_cnt - `MERGE_CREDIT_WIDTH'(1);
                2'b01:   r_credit_cnt <= r_credit_cnt + `MERGE_CREDIT_WIDTH'(1);
                default: r_credit_cnt <= r_credit_cnt;
            endcase
        end
    end

    assign o_data = r_data;
    assign o_tag  = r_tag;

endmodule

`default_nettype wire

/* merge_defines.svh */
`ifndef MERGE_DEFINES_SVH
`define MERGE_DEFINES_SVH

// payload width of one merged word
`define MERGE_DATA_WIDTH 32

// source-lane tag with one bit per tree level
`define MERGE_TAG_WIDTH 2

// entries per lane buffer
// also the credits each source holds after reset
`define MERGE_LANE_DEPTH 2

// downstream credits after reset
`define MERGE_OUT_CREDITS 4

// wide enough to hold the full output pool
`define MERGE_CREDIT_WIDTH 3

`endif

/* merge_lane_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module merge_lane_buffer (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_valid,
    input  logic [`MERGE_DATA_WIDTH-1:0] i_data,
    input  logic                         i_accept,
    output logic                         o_valid,
    output logic [`MERGE_DATA_WIDTH-1:0] o_data,
    output logic                         o_credit
);

    // pointers wrap on their own as the depth is a power of two
    localparam int PTR_W = $clog2(`MERGE_LANE_DEPTH);
    localparam int CNT_W = $clog2(`MERGE_LANE_DEPTH + 1);

    logic [`MERGE_DATA_WIDTH-1:0] r_mem [`MERGE_LANE_DEPTH];
    logic [PTR_W-1:0]             r_wr_ptr;
    logic [PTR_W-1:0]             r_rd_ptr;
    logic [CNT_W-1:0]             r_count;
    logic                         r_credit;
    logic                         w_pop;

    // head of queue always on the output
    assign o_valid  = (r_count != '0);
    assign o_data   = r_mem[r_rd_ptr];
    assign o_credit = r_credit;

    // word leaves when the switch grants this lane
    assign w_pop = o_valid && i_accept;

    // storage written on every source push
    always_ff @(posedge clk)
    begin
        if (i_valid)
        begin
            r_mem[r_wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_reset)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
            r_credit <= 1'b0;
        end
        else
        begin
            if (i_valid)
            begin
                r_wr_ptr <= r_wr_ptr + PTR_W'(1);
            end
            if (w_pop)
            begin
                r_rd_ptr <= r_rd_ptr + PTR_W'(1);
            end
            // push and pop together leave the count alone
            case ({i_valid, w_pop})
                2'b10:   r_count <= r_count + CNT_W'(1);
                2'b01:   r_count <= r_count - CNT_W'(1);
                default: r_count <= r_count;
            endcase
            // credit goes back one cycle after the pop
            r_credit <= w_pop;
        end
    end

endmodule

`default_nettype wire

/* merge_pkg.sv */
`default_nettype none

package merge_pkg;

    //////////////////////////////////////////////////////////////////////
    // command opcodes
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        CMD_ROUND_ROBIN = 2'd0,
        CMD_PRIO_LOW    = 2'd1,
        CMD_PRIO_HIGH   = 2'd2,
        CMD_HOLD        = 2'd3
    } merge_cmd_e;

    //////////////////////////////////////////////////////////////////////
    // arbitration modes seen by every switch
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0]
    {
        MODE_LAST_SERVED = 2'd0,
        MODE_FIX_LOW     = 2'd1,
        MODE_FIX_HIGH    = 2'd2,
        // switches take nothing and keep their pointers
        MODE_HOLD        = 2'd3
    } merge_mode_e;

endpackage

`default_nettype wire

/* merge_tree_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module merge_tree_sva (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic [3:0]             i_lane_valid,
    input  logic [3:0]             w_buf_valid,
    input  logic [3:0]             w_buf_accept,
    input  logic [1:0]             w_root_accept,
    input  merge_pkg::merge_mode_e w_mode,
    input  logic                   i_out_credit,
    input  logic                   o_valid
);

    import merge_pkg::*;

    int r_occ [4];
    int r_pool;

    // shadow occupancy and credit pool
    always @(posedge clk)
    begin
        if (i_reset)
        begin
            for (int l = 0; l < 4; l++)
            begin
                r_occ[l] <= 0;
            end
            r_pool <= `MERGE_OUT_CREDITS;
        end
        else
        begin
            for (int l = 0; l < 4; l++)
            begin
                r_occ[l] <= r_occ[l] + int'(i_lane_valid[l])
                            - int'(w_buf_valid[l] && w_buf_accept[l]);
            end
            r_pool <= r_pool - int'(o_valid) + int'(i_out_credit);
        end
    end

    for (genvar l = 0; l < 4; l++)
    begin : g_full
        assert property (@(posedge clk) disable iff (i_reset)
            i_lane_valid[l] |-> (r_occ[l] < `MERGE_LANE_DEPTH) || w_buf_accept[l])
            else $error("lane %0d written while full", l);
    end

    // a word issued without a credit drives the pool below zero
    assert property (@(posedge clk) disable iff (i_reset)
        (r_pool >= 0) && (r_pool <= `MERGE_OUT_CREDITS))
        else $error("output credit pool outside its bounds");

    assert property (@(posedge clk) i_reset |=> !o_valid)
        else $error("output valid right after reset");

    // hold mode grants nothing at any level
    assert property (@(posedge clk) disable iff (i_reset)
        (w_mode == MODE_HOLD) |-> (w_buf_accept == 4'b0 && w_root_accept == 2'b0))
        else $error("switch loaded a word in hold mode");

endmodule

bind merge_tree_top merge_tree_sva u_sva (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_lane_valid  (i_lane_valid),
    .w_buf_valid   (w_buf_valid),
    .w_buf_accept  (w_buf_accept),
    .w_root_accept (w_root_accept),
    .w_mode        (w_mode),
    .i_out_credit  (i_out_credit),
    .o_valid       (o_valid)
);

`default_nettype wire

/* merge_tree_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module merge_tree_top (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_cmd_valid,
    input  merge_pkg::merge_cmd_e        i_cmd,
    input  logic [3:0]                   i_lane_valid,
    input  logic [`MERGE_DATA_WIDTH-1:0] i_lane_data [4],
    input  logic                         i_out_credit,
    output logic [3:0]                   o_lane_credit,
    output logic                         o_valid,
    output logic [`MERGE_DATA_WIDTH-1:0] o_data,
    output logic [`MERGE_TAG_WIDTH-1:0]  o_tag
);

    import merge_pkg::*;

    merge_mode_e                  w_mode;
    logic [3:0]                   w_buf_valid;
    logic [3:0]                   w_buf_accept;
    logic [`MERGE_DATA_WIDTH-1:0] w_buf_data [4];
    // one bit per leaf
    logic [1:0]                   w_leaf_valid;
    logic [1:0]                   w_leaf_tag;
    logic [`MERGE_DATA_WIDTH-1:0] w_leaf_data [2];
    logic [1:0]                   w_root_accept;
    logic                         w_root_valid;
    logic [`MERGE_DATA_WIDTH-1:0] w_root_data;
    logic [`MERGE_TAG_WIDTH-1:0]  w_root_tag;
    logic                         w_out_accept;

    //////////////////////////////////////////////////////////////////////
    // lane buffers
    //////////////////////////////////////////////////////////////////////

    generate
        for (genvar l = 0; l < 4; l++)
        begin : g_lane
            merge_lane_buffer u_lane (
                .clk      (clk),
                .i_reset  (i_reset),
                .i_valid  (i_lane_valid[l]),
                .i_data   (i_lane_data[l]),
                .i_accept (w_buf_accept[l]),
                .o_valid  (w_buf_valid[l]),
                .o_data   (w_buf_data[l]),
                .o_credit (o_lane_credit[l])
            );
        end
    endgenerate

    merge_cmd_decode u_decode (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .o_mode      (w_mode)
    );

    //////////////////////////////////////////////////////////////////////
    // merge switches
    //////////////////////////////////////////////////////////////////////

    // leaves carry no tag in so their tag ports are tied low
    merge_2x1_seq #(.TAG_IN_WIDTH(0)) u_leaf0 (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_mode      (w_mode),
        .i_valid     (w_buf_valid[1:0]),
        .i_data_low  (w_buf_data[0]),
        .i_data_high (w_buf_data[1]),
        .i_tag_low   (1'b0),
        .i_tag_high  (1'b0),
        .i_accept    (w_root_accept[0]),
        .o_accept    (w_buf_accept[1:0]),
        .o_valid     (w_leaf_valid[0]),
        .o_data      (w_leaf_data[0]),
        .o_tag       (w_leaf_tag[0])
    );

    merge_2x1_seq #(.TAG_IN_WIDTH(0)) u_leaf1 (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_mode      (w_mode),
        .i_valid     (w_buf_valid[3:2]),
        .i_data_low  (w_buf_data[2]),
        .i_data_high (w_buf_data[3]),
        .i_tag_low   (1'b0),
        .i_tag_high  (1'b0),
        .i_accept    (w_root_accept[1]),
        .o_accept    (w_buf_accept[3:2]),
        .o_valid     (w_leaf_valid[1]),
        .o_data      (w_leaf_data[1]),
        .o_tag       (w_leaf_tag[1])
    );

    // root adds the upper lane bit
    merge_2x1_seq #(.TAG_IN_WIDTH(1)) u_root (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_mode      (w_mode),
        .i_valid     (w_leaf_valid),
        .i_data_low  (w_leaf_data[0]),
        .i_data_high (w_leaf_data[1]),
        .i_tag_low   (w_leaf_tag[0]),
        .i_tag_high  (w_leaf_tag[1]),
        .i_accept    (w_out_accept),
        .o_accept    (w_root_accept),
        .o_valid     (w_root_valid),
        .o_data      (w_root_data),
        .o_tag       (w_root_tag)
    );

    merge_credit_out u_out (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_valid      (w_root_valid),
        .i_data       (w_root_data),
        .i_tag        (w_root_tag),
        .i_out_credit (i_out_credit),
        .o_accept     (w_out_accept),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .o_tag        (o_tag)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_merge_tree -o sim_merge_tree

out=$(./obj_dir/sim_merge_tree 2>&1) || true
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

/* src.f */
+incdir+.
merge_pkg.sv
merge_lane_buffer.sv
merge_cmd_decode.sv
merge_2x1_seq.sv
merge_credit_out.sv
merge_tree_top.sv
merge_tree_sva.sv
tb_merge_tree.sv

/* tb_merge_tree.sv */
`timescale 1ns/10ps
`default_nettype none

`include "merge_defines.svh"

module tb_merge_tree;

    import merge_pkg::*;

    localparam int W  = `MERGE_DATA_WIDTH;
    localparam int TW = `MERGE_TAG_WIDTH;

    // per-test cycle bounds, summed for the watchdog
    localparam int T_SINGLE = 4 * 40;
    localparam int T_FIXED  = 2 * 120;
    localparam int T_FAIR   = 100;
    localparam int T_BACK   = 300;
    localparam int T_RANDOM = 500;
    localparam int T_RESET  = 100;
    localparam int LIMIT    = T_SINGLE + T_FIXED + T_FAIR + T_BACK + T_RANDOM + T_RESET + 200;

    // consumer credit policies
    localparam int POL_FAST = 0;
    localparam int POL_NONE = 1;
    localparam int POL_SLOW = 2;

    logic         clk;
    logic         i_reset;
    logic         i_cmd_valid;
    merge_cmd_e   i_cmd;
    logic [3:0]   i_lane_valid;
    logic [W-1:0] i_lane_data [4];
    logic         i_out_credit;
    logic [3:0]   o_lane_credit;
    logic         o_valid;
    logic [W-1:0] o_data;
    logic [TW-1:0] o_tag;

    int src_credit [4];
    int pending;
    int policy;
    int cycles = 0;
    int sent_count;

    logic [W-1:0]  exp_q [4][$];
    logic [W-1:0]  rx_data_q [$];
    logic [TW-1:0] rx_tag_q [$];

    merge_tree_top dut (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd         (i_cmd),
        .i_lane_valid  (i_lane_valid),
        .i_lane_data   (i_lane_data),
        .i_out_credit  (i_out_credit),
        .o_lane_credit (o_lane_credit),
        .o_valid       (o_valid),
        .o_data        (o_data),
        .o_tag         (o_tag)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input logic [W-1:0] got, input logic [W-1:0] exp,
                              input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s data %h, expected %h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_tag(input logic [TW-1:0] got, input logic [TW-1:0] exp,
                             input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s tag %0d, expected %0d", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "tag mismatch");
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // watchdog, monitor and consumer
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        cycles++;
        if (cycles > LIMIT)
        begin
            abort("timeout, the tests ran past their cycle budget");
        end
    end

    // outputs sampled mid-cycle where they are stable
    always @(negedge clk)
    begin
        if (o_valid)
        begin
            rx_data_q.push_back(o_data);
            rx_tag_q.push_back(o_tag);
            pending++;
        end
        for (int l = 0; l < 4; l++)
        begin
            if (o_lane_credit[l])
            begin
                src_credit[l]++;
            end
        end
    end

    // slow policy returns a credit every fourth cycle
    always @(posedge clk)
    begin
        if (pending > 0 && (policy == POL_FAST || (policy == POL_SLOW && cycles % 4 == 0)))
        begin
            i_out_credit <= 1'b1;
            pending--;
        end
        else
        begin
            i_out_credit <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    task automatic reset_tree(input int pol);
        @(posedge clk);
        i_reset      <= 1'b1;
        i_lane_valid <= '0;
        i_cmd_valid  <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        // model state back to its post-reset view
        for (int l = 0; l < 4; l++)
        begin
            src_credit[l] = `MERGE_LANE_DEPTH;
            exp_q[l].delete();
        end
        rx_data_q.delete();
        rx_tag_q.delete();
        pending    = 0;
        sent_count = 0;
        policy     = pol;
        @(posedge clk);
        i_reset <= 1'b0;
    endtask

    // sources only write while they hold a credit
    task automatic drive_lanes(input logic [3:0] mask);
        logic [W-1:0] d;
        @(posedge clk);
        i_cmd_valid <= 1'b0;
        for (int l = 0; l < 4; l++)
        begin
            if (mask[l] && src_credit[l] > 0)
            begin
                d = $urandom;
                i_lane_valid[l] <= 1'b1;
                i_lane_data[l]  <= d;
                src_credit[l]--;
                exp_q[l].push_back(d);
                sent_count++;
            end
            else
            begin
                i_lane_valid[l] <= 1'b0;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            i_lane_valid <= '0;
            i_cmd_valid  <= 1'b0;
        end
    endtask

    task automatic send_cmd(input merge_cmd_e c);
        @(posedge clk);
        i_lane_valid <= '0;
        i_cmd_valid  <= 1'b1;
        i_cmd        <= c;
        @(posedge clk);
        i_cmd_valid <= 1'b0;
    endtask

    task automatic wait_rx(input int n, input int limit);
        int waited;
        waited = 0;
        while (rx_data_q.size() < n)
        begin
            @(negedge clk);
            waited++;
            if (waited > limit)
            begin
                abort("expected words never came out of the tree");
            end
        end
    endtask

    task automatic wait_credits(input int limit);
        int waited;
        waited = 0;
        while (src_credit[0] != 2 || src_credit[1] != 2 || src_credit[2] != 2 ||
               src_credit[3] != 2)
        begin
            @(negedge clk);
            waited++;
            if (waited > limit)
            begin
                abort("a source never got all of its credits back");
            end
        end
    endtask

    // every word matched to the head of its own lane queue
    task automatic verify_rx(input string what);
        logic [W-1:0]  d;
        logic [TW-1:0] t;
        while (rx_data_q.size() > 0)
        begin
            d = rx_data_q.pop_front();
            t = rx_tag_q.pop_front();
            if (exp_q[t].size() == 0)
            begin
                abort("a word came out tagged with a lane that had nothing pending");
            end
            check_data(d, exp_q[t].pop_front(), what);
        end
        for (int l = 0; l < 4; l++)
        begin
            check_count(exp_q[l].size(), 0, "words still missing on a lane");
        end
    endtask

    task automatic preload(input merge_cmd_e c, input int n);
        send_cmd(CMD_HOLD);
        repeat (n) drive_lanes(4'hf);
        idle(3);
        send_cmd(c);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_pass_through();
        int cnt;
        bit found;
        reset_tree(POL_FAST);
        for (int l = 0; l < 4; l++)
        begin
            drive_lanes(4'(1 << l));
            cnt   = 0;
            found = 1'b0;
            while (!found && cnt < 10)
            begin
                @(posedge clk);
                i_lane_valid <= '0;
                cnt++;
                @(negedge clk);
                found = o_valid;
            end
            check_count(cnt, 4, "pass-through latency");
            wait_rx(1, 20);
            check_tag(rx_tag_q[0], TW'(l), "pass-through");
            verify_rx("pass-through");
            wait_credits(20);
        end
    endtask

    task automatic test_fixed_priority();
        reset_tree(POL_FAST);
        preload(CMD_PRIO_LOW, 2);
        wait_rx(8, 50);
        for (int i = 0; i < 8; i++)
        begin
            check_tag(rx_tag_q[i], TW'(i / 2), "low priority order");
        end
        verify_rx("low priority");
        wait_credits(20);
        preload(CMD_PRIO_HIGH, 2);
        wait_rx(8, 50);
        for (int i = 0; i < 8; i++)
        begin
            check_tag(rx_tag_q[i], TW'(3 - i / 2), "high priority order");
        end
        verify_rx("high priority");
        wait_credits(20);
    endtask

    task automatic test_last_served();
        reset_tree(POL_FAST);
        preload(CMD_ROUND_ROBIN, 1);
        wait_rx(4, 50);
        check_tag(rx_tag_q[0], 2'd0, "fair order");
        check_tag(rx_tag_q[1], 2'd2, "fair order");
        check_tag(rx_tag_q[2], 2'd1, "fair order");
        check_tag(rx_tag_q[3], 2'd3, "fair order");
        verify_rx("fair");
        wait_credits(20);
    endtask

    task automatic test_back_pressure();
        reset_tree(POL_NONE);
        repeat (2) drive_lanes(4'hf);
        idle(30);
        // nothing more may leave once the pool of four is spent
        check_count(rx_data_q.size(), `MERGE_OUT_CREDITS, "words out without credit return");
        @(negedge clk);
        policy = POL_SLOW;
        wait_rx(8, 150);
        wait_credits(50);
        verify_rx("back-pressure");
    endtask

    task automatic test_random();
        reset_tree(POL_FAST);
        repeat (60) drive_lanes(4'($urandom));
        idle(1);
        wait_rx(sent_count, 200);
        wait_credits(50);
        verify_rx("random traffic");
    endtask

    task automatic test_reset_mid();
        reset_tree(POL_FAST);
        repeat (10) drive_lanes(4'hf);
        reset_tree(POL_FAST);
        repeat (10)
        begin
            @(negedge clk);
            if (o_valid)
            begin
                abort("output went valid right after reset");
            end
            if (o_lane_credit != 4'b0)
            begin
                abort("a lane returned a credit right after reset");
            end
        end
        // a full buffer on every lane with nothing stale ahead of it
        repeat (`MERGE_LANE_DEPTH) drive_lanes(4'hf);
        idle(1);
        wait_rx(4 * `MERGE_LANE_DEPTH, 30);
        idle(10);
        check_count(rx_data_q.size(), 4 * `MERGE_LANE_DEPTH, "words out after reset");
        verify_rx("after reset");
        for (int l = 0; l < 4; l++)
        begin
            check_count(src_credit[l], `MERGE_LANE_DEPTH, "lane credits after reset");
        end
    endtask

    initial
    begin
        void'($urandom(32'hc022_8327));
        i_reset      = 1'b1;
        i_cmd_valid  = 1'b0;
        i_cmd        = CMD_ROUND_ROBIN;
        i_lane_valid = '0;
        i_out_credit = 1'b0;
        for (int l = 0; l < 4; l++)
        begin
            i_lane_data[l] = '0;
            src_credit[l]  = `MERGE_LANE_DEPTH;
        end
        pending    = 0;
        policy     = POL_FAST;
        sent_count = 0;

        test_pass_through();
        test_fixed_priority();
        test_last_served();
        test_back_pressure();
        test_random();
        test_reset_mid();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
